// File: hdl/ooo_pkg.sv
package ooo_pkg;

    // Data path and tag widths.
    localparam int XLEN      = 32;
    localparam int ROB_IDX_W = 5;

    localparam int RS_DEPTH  = 4;                 // Entries in the station, a power of two.
    localparam int RS_IDX_W  = $clog2(RS_DEPTH);  // Width of an entry index.

    localparam int ALU_OP_W  = 4;

    // ALU operation codes.
    localparam logic [ALU_OP_W-1:0] ALU_OP_ADD  = 4'd0;
    localparam logic [ALU_OP_W-1:0] ALU_OP_SUB  = 4'd1;
    localparam logic [ALU_OP_W-1:0] ALU_OP_SLL  = 4'd2;
    localparam logic [ALU_OP_W-1:0] ALU_OP_SLT  = 4'd3;
    localparam logic [ALU_OP_W-1:0] ALU_OP_SLTU = 4'd4;
    localparam logic [ALU_OP_W-1:0] ALU_OP_XOR  = 4'd5;
    localparam logic [ALU_OP_W-1:0] ALU_OP_SRL  = 4'd6;
    localparam logic [ALU_OP_W-1:0] ALU_OP_SRA  = 4'd7;
    localparam logic [ALU_OP_W-1:0] ALU_OP_OR   = 4'd8;
    localparam logic [ALU_OP_W-1:0] ALU_OP_AND  = 4'd9;
    localparam logic [ALU_OP_W-1:0] ALU_OP_NOP  = 4'd15;  // Gives a zero result.

    // RV32I major opcodes handled by this unit.
    localparam logic [6:0] OP_OP_IMM = 7'b0010011;
    localparam logic [6:0] OP_OP     = 7'b0110011;
    localparam logic [6:0] OP_LUI    = 7'b0110111;
    localparam logic [6:0] OP_AUIPC  = 7'b0010111;
    localparam logic [6:0] OP_JAL    = 7'b1101111;
    localparam logic [6:0] OP_JALR   = 7'b1100111;

    // funct3 encodings, shared by the register and immediate forms.
    localparam logic [2:0] FUNCT3_ADD_SUB = 3'b000;
    localparam logic [2:0] FUNCT3_SLL     = 3'b001;
    localparam logic [2:0] FUNCT3_SLT     = 3'b010;
    localparam logic [2:0] FUNCT3_SLTU    = 3'b011;
    localparam logic [2:0] FUNCT3_XOR     = 3'b100;
    localparam logic [2:0] FUNCT3_SR      = 3'b101;
    localparam logic [2:0] FUNCT3_OR      = 3'b110;
    localparam logic [2:0] FUNCT3_AND     = 3'b111;

    // funct7 encodings.
    localparam logic [6:0] FUNCT7_BASE = 7'b0000000;  // ADD and SRL.
    localparam logic [6:0] FUNCT7_ALT  = 7'b0100000;  // SUB and SRA.

endpackage

// File: hdl/alu.sv
`timescale 1ns/1ps

module alu (
    input  logic [ooo_pkg::XLEN-1:0]     alu_op1_i,
    input  logic [ooo_pkg::XLEN-1:0]     alu_op2_i,
    input  logic [ooo_pkg::ALU_OP_W-1:0] alu_func_i,
    output logic [ooo_pkg::XLEN-1:0]     alu_out_o
);

    logic [4:0] shift_amt;

    assign shift_amt = alu_op2_i[4:0];  // Only the low five bits count for a 32-bit shift.

    always_comb begin
        case (alu_func_i)
            ooo_pkg::ALU_OP_ADD: begin
                alu_out_o = alu_op1_i + alu_op2_i;
            end
            ooo_pkg::ALU_OP_SUB: begin
                alu_out_o = alu_op1_i - alu_op2_i;
            end
            ooo_pkg::ALU_OP_SLL: begin
                alu_out_o = alu_op1_i << shift_amt;
            end
            ooo_pkg::ALU_OP_SLT: begin
                alu_out_o = ($signed(alu_op1_i) < $signed(alu_op2_i)) ?
                            ooo_pkg::XLEN'(1) : '0;
            end
            ooo_pkg::ALU_OP_SLTU: begin
                alu_out_o = (alu_op1_i < alu_op2_i) ? ooo_pkg::XLEN'(1) : '0;
            end
            ooo_pkg::ALU_OP_XOR: begin
                alu_out_o = alu_op1_i ^ alu_op2_i;
            end
            ooo_pkg::ALU_OP_SRL: begin
                alu_out_o = alu_op1_i >> shift_amt;
            end
            ooo_pkg::ALU_OP_SRA: begin
                alu_out_o = $unsigned($signed(alu_op1_i) >>> shift_amt);
            end
            ooo_pkg::ALU_OP_OR: begin
                alu_out_o = alu_op1_i | alu_op2_i;
            end
            ooo_pkg::ALU_OP_AND: begin
                alu_out_o = alu_op1_i & alu_op2_i;
            end
            default: begin
                alu_out_o = '0;  // NOP and unused codes.
            end
        endcase
    end

endmodule

// File: hdl/arith.sv
`timescale 1ns/1ps

module arith (
    input  logic [ooo_pkg::XLEN-1:0]      pc_i,
    input  logic                          issue_i,
    input  logic [31:0]                   inst_i,
    input  logic [ooo_pkg::XLEN-1:0]      rs1_value_i,
    input  logic [ooo_pkg::XLEN-1:0]      rs2_value_i,
    input  logic [ooo_pkg::ROB_IDX_W-1:0] rob_idx_i,
    output logic                          writeback_valid_o,
    output logic [ooo_pkg::XLEN-1:0]      writeback_value_o,
    output logic [ooo_pkg::ROB_IDX_W-1:0] rob_idx_o
);

    logic [6:0]                   opcode;
    logic [2:0]                   funct3;
    logic [6:0]                   funct7;
    logic [ooo_pkg::XLEN-1:0]     imm_i;
    logic [ooo_pkg::XLEN-1:0]     imm_u;
    logic [ooo_pkg::XLEN-1:0]     shamt;
    logic [ooo_pkg::XLEN-1:0]     alu_operand1;
    logic [ooo_pkg::XLEN-1:0]     alu_operand2;
    logic [ooo_pkg::ALU_OP_W-1:0] alu_func;
    logic [ooo_pkg::XLEN-1:0]     alu_out;

    assign opcode = inst_i[6:0];
    assign funct3 = inst_i[14:12];
    assign funct7 = inst_i[31:25];

    assign imm_i = {{(ooo_pkg::XLEN-12){inst_i[31]}}, inst_i[31:20]};
    assign imm_u = {inst_i[31:12], 12'b0};
    assign shamt = {{(ooo_pkg::XLEN-5){1'b0}}, inst_i[24:20]};

    // Tag and strobe travel with the combinational result.
    assign writeback_valid_o = issue_i;
    assign writeback_value_o = alu_out;
    assign rob_idx_o         = rob_idx_i;

    alu i_alu (
        .alu_op1_i  (alu_operand1),
        .alu_op2_i  (alu_operand2),
        .alu_func_i (alu_func),
        .alu_out_o  (alu_out)
    );

    always_comb begin
        alu_operand1 = rs1_value_i;
        alu_operand2 = rs2_value_i;
        alu_func     = ooo_pkg::ALU_OP_NOP;
        case (opcode)
            ooo_pkg::OP_OP_IMM: begin
                alu_operand2 = imm_i;
                case (funct3)
                    ooo_pkg::FUNCT3_ADD_SUB: alu_func = ooo_pkg::ALU_OP_ADD;
                    ooo_pkg::FUNCT3_SLT:     alu_func = ooo_pkg::ALU_OP_SLT;
                    ooo_pkg::FUNCT3_SLTU:    alu_func = ooo_pkg::ALU_OP_SLTU;
                    ooo_pkg::FUNCT3_XOR:     alu_func = ooo_pkg::ALU_OP_XOR;
                    ooo_pkg::FUNCT3_OR:      alu_func = ooo_pkg::ALU_OP_OR;
                    ooo_pkg::FUNCT3_AND:     alu_func = ooo_pkg::ALU_OP_AND;
                    ooo_pkg::FUNCT3_SLL: begin
                        alu_operand2 = shamt;
                        if (funct7 == ooo_pkg::FUNCT7_BASE) begin
                            alu_func = ooo_pkg::ALU_OP_SLL;
                        end
                    end
                    default: begin  // Shift right, arithmetic when funct7 is ALT.
                        alu_operand2 = shamt;
                        if (funct7 == ooo_pkg::FUNCT7_BASE) begin
                            alu_func = ooo_pkg::ALU_OP_SRL;
                        end else if (funct7 == ooo_pkg::FUNCT7_ALT) begin
                            alu_func = ooo_pkg::ALU_OP_SRA;
                        end
                    end
                endcase
            end
            ooo_pkg::OP_OP: begin
                if (funct7 == ooo_pkg::FUNCT7_BASE) begin
                    case (funct3)
                        ooo_pkg::FUNCT3_ADD_SUB: alu_func = ooo_pkg::ALU_OP_ADD;
                        ooo_pkg::FUNCT3_SLL:     alu_func = ooo_pkg::ALU_OP_SLL;
                        ooo_pkg::FUNCT3_SLT:     alu_func = ooo_pkg::ALU_OP_SLT;
                        ooo_pkg::FUNCT3_SLTU:    alu_func = ooo_pkg::ALU_OP_SLTU;
                        ooo_pkg::FUNCT3_XOR:     alu_func = ooo_pkg::ALU_OP_XOR;
                        ooo_pkg::FUNCT3_SR:      alu_func = ooo_pkg::ALU_OP_SRL;
                        ooo_pkg::FUNCT3_OR:      alu_func = ooo_pkg::ALU_OP_OR;
                        default:                 alu_func = ooo_pkg::ALU_OP_AND;
                    endcase
                end else if (funct7 == ooo_pkg::FUNCT7_ALT) begin
                    if (funct3 == ooo_pkg::FUNCT3_ADD_SUB) begin
                        alu_func = ooo_pkg::ALU_OP_SUB;
                    end else if (funct3 == ooo_pkg::FUNCT3_SR) begin
                        alu_func = ooo_pkg::ALU_OP_SRA;
                    end
                end
            end
            ooo_pkg::OP_LUI: begin
                alu_operand1 = imm_u;
                alu_operand2 = '0;
                alu_func     = ooo_pkg::ALU_OP_OR;
            end
            ooo_pkg::OP_AUIPC: begin
                alu_operand1 = pc_i;
                alu_operand2 = imm_u;
                alu_func     = ooo_pkg::ALU_OP_ADD;
            end
            ooo_pkg::OP_JAL, ooo_pkg::OP_JALR: begin
                alu_operand1 = pc_i;                 // Link value is pc plus 4.
                alu_operand2 = ooo_pkg::XLEN'(4);
                alu_func     = ooo_pkg::ALU_OP_ADD;
            end
            default: begin
                alu_func = ooo_pkg::ALU_OP_NOP;      // Unknown opcode writes back zero.
            end
        endcase
    end

endmodule

// File: hdl/arith_rs.sv
`timescale 1ns/1ps

module arith_rs (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          dispatch_i,
    input  logic [ooo_pkg::XLEN-1:0]      disp_pc_i,
    input  logic [31:0]                   disp_inst_i,
    input  logic [ooo_pkg::ROB_IDX_W-1:0] disp_rob_idx_i,
    input  logic [ooo_pkg::XLEN-1:0]      disp_rs1_value_i,
    input  logic                          disp_rs1_valid_i,
    input  logic [ooo_pkg::ROB_IDX_W-1:0] disp_rs1_tag_i,
    input  logic [ooo_pkg::XLEN-1:0]      disp_rs2_value_i,
    input  logic                          disp_rs2_valid_i,
    input  logic [ooo_pkg::ROB_IDX_W-1:0] disp_rs2_tag_i,
    output logic                          rs_full_o,
    input  logic                          wake0_valid_i,
    input  logic [ooo_pkg::ROB_IDX_W-1:0] wake0_rob_idx_i,
    input  logic [ooo_pkg::XLEN-1:0]      wake0_value_i,
    input  logic                          wake1_valid_i,
    input  logic [ooo_pkg::ROB_IDX_W-1:0] wake1_rob_idx_i,
    input  logic [ooo_pkg::XLEN-1:0]      wake1_value_i,
    output logic                          issue_valid_o,
    output logic [ooo_pkg::XLEN-1:0]      issue_pc_o,
    output logic [31:0]                   issue_inst_o,
    output logic [ooo_pkg::XLEN-1:0]      issue_rs1_value_o,
    output logic [ooo_pkg::XLEN-1:0]      issue_rs2_value_o,
    output logic [ooo_pkg::ROB_IDX_W-1:0] issue_rob_idx_o
);

    logic [ooo_pkg::RS_DEPTH-1:0]  busy_q;
    logic [ooo_pkg::RS_DEPTH-1:0]  busy_next;
    logic [ooo_pkg::RS_DEPTH-1:0]  ready;
    logic [ooo_pkg::RS_DEPTH-1:0]  issue_grant;
    logic [ooo_pkg::RS_IDX_W-1:0]  issue_idx;
    logic [ooo_pkg::RS_IDX_W-1:0]  free_idx;
    logic                          disp_take;

    logic [ooo_pkg::XLEN-1:0]      pc_q        [ooo_pkg::RS_DEPTH];
    logic [31:0]                   inst_q      [ooo_pkg::RS_DEPTH];
    logic [ooo_pkg::ROB_IDX_W-1:0] rob_idx_q   [ooo_pkg::RS_DEPTH];
    logic                          rs1_valid_q [ooo_pkg::RS_DEPTH];
    logic [ooo_pkg::ROB_IDX_W-1:0] rs1_tag_q   [ooo_pkg::RS_DEPTH];
    logic [ooo_pkg::XLEN-1:0]      rs1_value_q [ooo_pkg::RS_DEPTH];
    logic                          rs2_valid_q [ooo_pkg::RS_DEPTH];
    logic [ooo_pkg::ROB_IDX_W-1:0] rs2_tag_q   [ooo_pkg::RS_DEPTH];
    logic [ooo_pkg::XLEN-1:0]      rs2_value_q [ooo_pkg::RS_DEPTH];

    // Returns the operand as {valid, value} after snooping both broadcast ports.
    function automatic logic [ooo_pkg::XLEN:0] snoop(
        input logic                          valid,
        input logic [ooo_pkg::ROB_IDX_W-1:0] tag,
        input logic [ooo_pkg::XLEN-1:0]      value
    );
        if (valid) begin
            return {1'b1, value};
        end
        if (wake0_valid_i && wake0_rob_idx_i == tag) begin
            return {1'b1, wake0_value_i};
        end
        if (wake1_valid_i && wake1_rob_idx_i == tag) begin
            return {1'b1, wake1_value_i};
        end
        return {1'b0, value};
    endfunction

    assign disp_take = dispatch_i & ~rs_full_o;

    always_comb begin
        issue_idx   = '0;
        free_idx    = '0;
        issue_grant = '0;
        for (int i = 0; i < ooo_pkg::RS_DEPTH; i++) begin
            ready[i] = busy_q[i] & rs1_valid_q[i] & rs2_valid_q[i];
        end
        // Walk downwards so the lowest index wins.
        for (int i = ooo_pkg::RS_DEPTH - 1; i >= 0; i--) begin
            if (ready[i]) begin
                issue_idx = ooo_pkg::RS_IDX_W'(i);
            end
        end
        issue_grant[issue_idx] = |ready;
        for (int i = ooo_pkg::RS_DEPTH - 1; i >= 0; i--) begin
            if (!busy_q[i] || issue_grant[i]) begin
                free_idx = ooo_pkg::RS_IDX_W'(i);      // A slot issuing now may be refilled.
            end
        end
        busy_next = busy_q & ~issue_grant;
        if (disp_take) begin
            busy_next[free_idx] = 1'b1;
        end
    end

    assign issue_valid_o     = |ready;
    assign issue_pc_o        = pc_q[issue_idx];
    assign issue_inst_o      = inst_q[issue_idx];
    assign issue_rs1_value_o = rs1_value_q[issue_idx];
    assign issue_rs2_value_o = rs2_value_q[issue_idx];
    assign issue_rob_idx_o   = rob_idx_q[issue_idx];

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            busy_q    <= '0;
            rs_full_o <= 1'b0;
        end else begin
            busy_q    <= busy_next;
            rs_full_o <= &busy_next;  // Registered level, seen by dispatch next cycle.
        end
    end

    always_ff @(posedge clk_i) begin
        for (int i = 0; i < ooo_pkg::RS_DEPTH; i++) begin
            if (disp_take && free_idx == ooo_pkg::RS_IDX_W'(i)) begin
                pc_q[i]      <= disp_pc_i;
                inst_q[i]    <= disp_inst_i;
                rob_idx_q[i] <= disp_rob_idx_i;
                rs1_tag_q[i] <= disp_rs1_tag_i;
                rs2_tag_q[i] <= disp_rs2_tag_i;
                {rs1_valid_q[i], rs1_value_q[i]} <=
                    snoop(disp_rs1_valid_i, disp_rs1_tag_i, disp_rs1_value_i);
                {rs2_valid_q[i], rs2_value_q[i]} <=
                    snoop(disp_rs2_valid_i, disp_rs2_tag_i, disp_rs2_value_i);
            end else begin
                {rs1_valid_q[i], rs1_value_q[i]} <=
                    snoop(rs1_valid_q[i], rs1_tag_q[i], rs1_value_q[i]);
                {rs2_valid_q[i], rs2_value_q[i]} <=
                    snoop(rs2_valid_q[i], rs2_tag_q[i], rs2_value_q[i]);
            end
        end
    end

endmodule

// File: hdl/arith_unit_top.sv
`timescale 1ns/1ps

module arith_unit_top (
    input  logic                          clk_i,
    input  logic                          rst_n_i,
    input  logic                          dispatch_i,
    input  logic [ooo_pkg::XLEN-1:0]      disp_pc_i,
    input  logic [31:0]                   disp_inst_i,
    input  logic [ooo_pkg::ROB_IDX_W-1:0] disp_rob_idx_i,
    input  logic [ooo_pkg::XLEN-1:0]      disp_rs1_value_i,
    input  logic                          disp_rs1_valid_i,
    input  logic [ooo_pkg::ROB_IDX_W-1:0] disp_rs1_tag_i,
    input  logic [ooo_pkg::XLEN-1:0]      disp_rs2_value_i,
    input  logic                          disp_rs2_valid_i,
    input  logic [ooo_pkg::ROB_IDX_W-1:0] disp_rs2_tag_i,
    output logic                          rs_full_o,
    input  logic                          ext_cdb_valid_i,
    input  logic [ooo_pkg::ROB_IDX_W-1:0] ext_cdb_rob_idx_i,
    input  logic [ooo_pkg::XLEN-1:0]      ext_cdb_value_i,
    output logic                          cdb_valid_o,
    output logic [ooo_pkg::ROB_IDX_W-1:0] cdb_rob_idx_o,
    output logic [ooo_pkg::XLEN-1:0]      cdb_value_o
);

    logic                          issue_valid;
    logic [ooo_pkg::XLEN-1:0]      issue_pc;
    logic [31:0]                   issue_inst;
    logic [ooo_pkg::XLEN-1:0]      issue_rs1_value;
    logic [ooo_pkg::XLEN-1:0]      issue_rs2_value;
    logic [ooo_pkg::ROB_IDX_W-1:0] issue_rob_idx;
    logic                          wb_valid;
    logic [ooo_pkg::XLEN-1:0]      wb_value;
    logic [ooo_pkg::ROB_IDX_W-1:0] wb_rob_idx;

    arith_rs i_arith_rs (
        .clk_i             (clk_i),
        .rst_n_i           (rst_n_i),
        .dispatch_i        (dispatch_i),
        .disp_pc_i         (disp_pc_i),
        .disp_inst_i       (disp_inst_i),
        .disp_rob_idx_i    (disp_rob_idx_i),
        .disp_rs1_value_i  (disp_rs1_value_i),
        .disp_rs1_valid_i  (disp_rs1_valid_i),
        .disp_rs1_tag_i    (disp_rs1_tag_i),
        .disp_rs2_value_i  (disp_rs2_value_i),
        .disp_rs2_valid_i  (disp_rs2_valid_i),
        .disp_rs2_tag_i    (disp_rs2_tag_i),
        .rs_full_o         (rs_full_o),
        .wake0_valid_i     (ext_cdb_valid_i),
        .wake0_rob_idx_i   (ext_cdb_rob_idx_i),
        .wake0_value_i     (ext_cdb_value_i),
        .wake1_valid_i     (cdb_valid_o),      // Own result feeds back as a wakeup.
        .wake1_rob_idx_i   (cdb_rob_idx_o),
        .wake1_value_i     (cdb_value_o),
        .issue_valid_o     (issue_valid),
        .issue_pc_o        (issue_pc),
        .issue_inst_o      (issue_inst),
        .issue_rs1_value_o (issue_rs1_value),
        .issue_rs2_value_o (issue_rs2_value),
        .issue_rob_idx_o   (issue_rob_idx)
    );

    arith i_arith (
        .pc_i              (issue_pc),
        .issue_i           (issue_valid),
        .inst_i            (issue_inst),
        .rs1_value_i       (issue_rs1_value),
        .rs2_value_i       (issue_rs2_value),
        .rob_idx_i         (issue_rob_idx),
        .writeback_valid_o (wb_valid),
        .writeback_value_o (wb_value),
        .rob_idx_o         (wb_rob_idx)
    );

    always_ff @(posedge clk_i or negedge rst_n_i) begin
        if (!rst_n_i) begin
            cdb_valid_o <= 1'b0;
        end else begin
            cdb_valid_o <= wb_valid;  // High for one cycle per issued instruction.
        end
    end

    always_ff @(posedge clk_i) begin
        cdb_value_o   <= wb_value;
        cdb_rob_idx_o <= wb_rob_idx;
    end

endmodule

// File: sim/tb_clock_gen.sv
`timescale 1ns/1ps

module tb_clock_gen (
    output logic clk_o,
    output logic rst_n_o
);

    localparam int HALF_PERIOD  = 20;  // 40 ns clock.
    localparam int RESET_CYCLES = 4;

    initial begin
        clk_o = 1'b0;
        forever #(HALF_PERIOD) clk_o = ~clk_o;
    end

    initial begin
        rst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        @(negedge clk_o);  // Release away from the active edge.
        rst_n_o = 1'b1;
    end

endmodule

// File: sim/tb_arith_unit.sv
`timescale 1ns/1ps

module tb_arith_unit;

    localparam int N_RANDOM   = 60;
    localparam int N_WAKE     = 12;
    localparam int N_CHAIN    = 16;
    localparam int N_TOTAL    = N_RANDOM + N_WAKE + N_CHAIN + ooo_pkg::RS_DEPTH;
    localparam int MAX_CYCLES = 20 * N_TOTAL + 200;
    localparam int TAGS       = 2 ** ooo_pkg::ROB_IDX_W;
    localparam int OWN_TAGS   = 24;  // Tags from 24 up belong to producers outside the unit.

    logic                          clk_i;
    logic                          rst_n_i;
    logic                          dispatch_i;
    logic [ooo_pkg::XLEN-1:0]      disp_pc_i;
    logic [31:0]                   disp_inst_i;
    logic [ooo_pkg::ROB_IDX_W-1:0] disp_rob_idx_i;
    logic [ooo_pkg::XLEN-1:0]      disp_rs1_value_i;
    logic                          disp_rs1_valid_i;
    logic [ooo_pkg::ROB_IDX_W-1:0] disp_rs1_tag_i;
    logic [ooo_pkg::XLEN-1:0]      disp_rs2_value_i;
    logic                          disp_rs2_valid_i;
    logic [ooo_pkg::ROB_IDX_W-1:0] disp_rs2_tag_i;
    logic                          rs_full_o;
    logic                          ext_cdb_valid_i;
    logic [ooo_pkg::ROB_IDX_W-1:0] ext_cdb_rob_idx_i;
    logic [ooo_pkg::XLEN-1:0]      ext_cdb_value_i;
    logic                          cdb_valid_o;
    logic [ooo_pkg::ROB_IDX_W-1:0] cdb_rob_idx_o;
    logic [ooo_pkg::XLEN-1:0]      cdb_value_o;

    logic [31:0] exp_value    [TAGS];
    logic [7:0]  issued_cnt   [TAGS];
    logic [7:0]  returned_cnt [TAGS];
    logic        waiting      [TAGS];  // Set while an operand waits for an external broadcast.
    logic [4:0]  waiting_on   [TAGS];
    logic        any_dispatched;
    logic [31:0] lfsr_state;
    int          cycle_count = 0;

    tb_clock_gen i_clock_gen (.clk_o(clk_i), .rst_n_o(rst_n_i));

    arith_unit_top i_dut (.*);

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("Some tests failed");
        $fatal(1, "Run stopped at the first error.");
    endtask

    function automatic logic [31:0] take_bits(input int n);
        logic [31:0] bits;
        logic        feedback;
        bits = '0;
        for (int i = 0; i < n; i++) begin
            feedback   = lfsr_state[31] ^ lfsr_state[21] ^ lfsr_state[1] ^ lfsr_state[0];
            lfsr_state = {lfsr_state[30:0], feedback};
            bits       = {bits[30:0], feedback};
        end
        return bits;
    endfunction

    // Gives the RV32I result for a funct3 value and alt selects SUB or SRA.
    function automatic logic [31:0] op_result(input logic [2:0] f3, input logic alt,
                                              input logic [31:0] a, input logic [31:0] b);
        case (f3)
            3'b000:  return alt ? a - b : a + b;
            3'b001:  return a << b[4:0];
            3'b010:  return {31'b0, ($signed(a) < $signed(b))};
            3'b011:  return {31'b0, (a < b)};
            3'b100:  return a ^ b;
            3'b101:  return alt ? $unsigned($signed(a) >>> b[4:0]) : a >> b[4:0];
            3'b110:  return a | b;
            default: return a & b;
        endcase
    endfunction

    function automatic logic [31:0] expected_result(input logic [31:0] inst,
                                                    input logic [31:0] pc,
                                                    input logic [31:0] a, input logic [31:0] b);
        logic [31:0] imm_i;
        logic [2:0]  f3;
        logic [6:0]  f7;
        imm_i = {{20{inst[31]}}, inst[31:20]};
        f3    = inst[14:12];
        f7    = inst[31:25];
        case (inst[6:0])
            7'b0010011: begin  // Only the immediate shifts look at funct7.
                if (f3 == 3'b001 && f7 != 7'h00) return 32'b0;
                if (f3 == 3'b101 && f7 != 7'h00 && f7 != 7'h20) return 32'b0;
                return op_result(f3, f3 == 3'b101 && f7 == 7'h20, a, imm_i);
            end
            7'b0110011: begin
                if (f7 == 7'h00) return op_result(f3, 1'b0, a, b);
                if (f7 == 7'h20 && (f3 == 3'b000 || f3 == 3'b101)) begin
                    return op_result(f3, 1'b1, a, b);
                end
                return 32'b0;
            end
            7'b0110111:             return {inst[31:12], 12'b0};
            7'b0010111:             return pc + {inst[31:12], 12'b0};
            7'b1101111, 7'b1100111: return pc + 32'd4;
            default:                return 32'b0;
        endcase
    endfunction

    function automatic logic [31:0] random_inst();
        logic [31:0] inst;
        logic [2:0]  kind;
        logic [1:0]  f7_sel;
        inst   = take_bits(32);
        kind   = take_bits(3);
        f7_sel = take_bits(2);
        case (kind)
            3'd0, 3'd1: inst[6:0] = 7'b0110011;
            3'd2, 3'd3: inst[6:0] = 7'b0010011;
            3'd4:       inst[6:0] = 7'b0110111;
            3'd5:       inst[6:0] = 7'b0010111;
            3'd6:       inst[6:0] = 7'b1101111;
            default:    inst[6:0] = 7'b1100111;
        endcase
        // Most funct7 fields are made legal and some keep an undefined random value.
        if (kind < 3'd2 || (kind < 3'd4 && inst[13:12] == 2'b01)) begin
            if (f7_sel < 2'd2) begin
                inst[31:25] = 7'h00;
            end else if (f7_sel == 2'd2) begin
                inst[31:25] = 7'h20;
            end
        end
        return inst;
    endfunction

    function automatic logic [4:0] free_tag();
        logic [4:0] tag;
        logic [4:0] pick;
        logic       found;
        tag   = 5'(take_bits(5) % OWN_TAGS);
        pick  = tag;
        found = 1'b0;
        for (int i = 0; i < OWN_TAGS; i++) begin
            if (!found && issued_cnt[tag] == returned_cnt[tag]) begin
                pick  = tag;
                found = 1'b1;
            end
            tag = (tag == 5'(OWN_TAGS - 1)) ? 5'd0 : tag + 5'd1;
        end
        return pick;
    endfunction

    task automatic dispatch_one(input logic [31:0] inst, input logic [31:0] pc,
                                input logic [4:0] tag, input logic [31:0] result,
                                input logic [31:0] a, input logic a_ok, input logic [4:0] a_tag,
                                input logic [31:0] b, input logic b_ok, input logic [4:0] b_tag);
        while (rs_full_o) @(negedge clk_i);
        dispatch_i       = 1'b1;
        disp_inst_i      = inst;
        disp_pc_i        = pc;
        disp_rob_idx_i   = tag;
        disp_rs1_value_i = a;
        disp_rs1_valid_i = a_ok;
        disp_rs1_tag_i   = a_tag;
        disp_rs2_value_i = b;
        disp_rs2_valid_i = b_ok;
        disp_rs2_tag_i   = b_tag;
        exp_value[tag]   = result;
        issued_cnt[tag]  = issued_cnt[tag] + 8'd1;
        any_dispatched   = 1'b1;
        @(negedge clk_i);
        dispatch_i = 1'b0;
    endtask

    task automatic broadcast_ext(input logic [4:0] tag, input logic [31:0] value);
        ext_cdb_valid_i   = 1'b1;
        ext_cdb_rob_idx_i = tag;
        ext_cdb_value_i   = value;
        for (int i = 0; i < TAGS; i++) begin
            if (waiting[i] && waiting_on[i] == tag) waiting[i] = 1'b0;
        end
        @(negedge clk_i);
        ext_cdb_valid_i = 1'b0;
    endtask

    task automatic wait_until_idle();
        int busy;
        do begin
            @(negedge clk_i);
            busy = 0;
            for (int i = 0; i < TAGS; i++) begin
                if (issued_cnt[i] != returned_cnt[i]) busy++;
            end
        end while (busy != 0);
    endtask

    always @(posedge clk_i) begin
        if (!rst_n_i) begin
            for (int i = 0; i < TAGS; i++) returned_cnt[i] <= '0;
        end else if (cdb_valid_o) begin
            returned_cnt[cdb_rob_idx_o] <= returned_cnt[cdb_rob_idx_o] + 8'd1;
        end
    end

    always @(posedge clk_i) begin
        cycle_count <= cycle_count + 1;
        if (cycle_count >= MAX_CYCLES) begin
            report_failure($sformatf("Timeout after %0d cycles with results still missing.",
                                     cycle_count));
        end
    end

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        !any_dispatched |-> !cdb_valid_o && !rs_full_o)
        else report_failure($sformatf("Fail at %0t: cdb_valid_o/rs_full_o is %b/%b, expected 0/0",
                                      $time, $sampled(cdb_valid_o), $sampled(rs_full_o)));

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cdb_valid_o |-> issued_cnt[cdb_rob_idx_o] != returned_cnt[cdb_rob_idx_o])
        else report_failure($sformatf("At %0t a result came back for tag %0d with none in flight.",
                                      $time, $sampled(cdb_rob_idx_o)));

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cdb_valid_o |-> cdb_value_o == exp_value[cdb_rob_idx_o])
        else report_failure($sformatf("Fail at %0t: cdb_value_o for tag %0d is %h, expected %h",
                                      $time, $sampled(cdb_rob_idx_o), $sampled(cdb_value_o),
                                      exp_value[$sampled(cdb_rob_idx_o)]));

    assert property (@(posedge clk_i) disable iff (!rst_n_i)
        cdb_valid_o |-> !waiting[cdb_rob_idx_o])
        else report_failure($sformatf("At %0t tag %0d finished before its operand was broadcast.",
                                      $time, $sampled(cdb_rob_idx_o)));

    initial begin
        logic [31:0] inst;
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] wake_value;
        logic [31:0] fill_value [ooo_pkg::RS_DEPTH];
        logic [4:0]  tag;
        logic [4:0]  prev_tag;
        logic [4:0]  ext_tag;
        logic        a_ok;
        lfsr_state        = 32'h46b6;
        any_dispatched    = 1'b0;
        dispatch_i        = 1'b0;
        disp_pc_i         = '0;
        disp_inst_i       = '0;
        disp_rob_idx_i    = '0;
        disp_rs1_value_i  = '0;
        disp_rs1_valid_i  = 1'b0;
        disp_rs1_tag_i    = '0;
        disp_rs2_value_i  = '0;
        disp_rs2_valid_i  = 1'b0;
        disp_rs2_tag_i    = '0;
        ext_cdb_valid_i   = 1'b0;
        ext_cdb_rob_idx_i = '0;
        ext_cdb_value_i   = '0;
        for (int i = 0; i < TAGS; i++) begin
            issued_cnt[i] = '0;
            waiting[i]    = 1'b0;
            waiting_on[i] = '0;
        end
        wait (rst_n_i);
        repeat (3) @(negedge clk_i);  // Idle cycles show the quiet outputs after reset.

        repeat (N_RANDOM) begin
            inst = random_inst();
            pc   = take_bits(30) << 2;
            a    = take_bits(32);
            b    = take_bits(32);
            tag  = free_tag();
            dispatch_one(inst, pc, tag, expected_result(inst, pc, a, b),
                         a, 1'b1, tag, b, 1'b1, tag);
            if (take_bits(2) == 0) @(negedge clk_i);
        end

        for (int k = 0; k < N_WAKE; k++) begin
            inst       = random_inst();
            pc         = take_bits(30) << 2;
            a          = take_bits(32);
            b          = take_bits(32);
            wake_value = take_bits(32);
            ext_tag    = 5'(OWN_TAGS + k % 8);
            tag        = free_tag();
            waiting[tag]    = 1'b1;
            waiting_on[tag] = ext_tag;
            if (take_bits(1) == 1) begin
                dispatch_one(inst, pc, tag, expected_result(inst, pc, a, wake_value),
                             a, 1'b1, tag, ~wake_value, 1'b0, ext_tag);
            end else begin
                dispatch_one(inst, pc, tag, expected_result(inst, pc, wake_value, b),
                             ~wake_value, 1'b0, ext_tag, b, 1'b1, tag);
            end
            repeat (take_bits(2)) @(negedge clk_i);
            broadcast_ext(ext_tag, wake_value);
        end
        wait_until_idle();

        prev_tag = '0;
        for (int k = 0; k < N_CHAIN; k++) begin
            while (rs_full_o) @(negedge clk_i);
            inst = random_inst();
            pc   = take_bits(30) << 2;
            a    = take_bits(32);
            b    = take_bits(32);
            a_ok = 1'b1;
            if (k > 0) begin
                a    = exp_value[prev_tag];
                a_ok = (issued_cnt[prev_tag] == returned_cnt[prev_tag]);  // Producer done.
            end
            tag = free_tag();
            dispatch_one(inst, pc, tag, expected_result(inst, pc, a, b),
                         a_ok ? a : ~a, a_ok, prev_tag, b, 1'b1, tag);
            prev_tag = tag;
        end
        wait_until_idle();

        for (int k = 0; k < ooo_pkg::RS_DEPTH; k++) begin
            inst          = random_inst();
            pc            = take_bits(30) << 2;
            b             = take_bits(32);
            fill_value[k] = take_bits(32);
            ext_tag       = 5'(OWN_TAGS + k);
            tag           = free_tag();
            waiting[tag]    = 1'b1;
            waiting_on[tag] = ext_tag;
            dispatch_one(inst, pc, tag, expected_result(inst, pc, fill_value[k], b),
                         ~fill_value[k], 1'b0, ext_tag, b, 1'b1, tag);
        end
        assert (rs_full_o)
            else report_failure($sformatf("Fail at %0t: rs_full_o is %b, expected 1",
                                          $time, rs_full_o));
        broadcast_ext(5'(OWN_TAGS), fill_value[0]);
        assert (rs_full_o)  // The woken entry issues on the next edge.
            else report_failure($sformatf("Fail at %0t: rs_full_o is %b, expected 1",
                                          $time, rs_full_o));
        @(negedge clk_i);
        assert (!rs_full_o)
            else report_failure($sformatf("Fail at %0t: rs_full_o is %b, expected 0",
                                          $time, rs_full_o));
        for (int k = 1; k < ooo_pkg::RS_DEPTH; k++) begin
            broadcast_ext(5'(OWN_TAGS + k), fill_value[k]);
        end
        wait_until_idle();
        repeat (4) @(negedge clk_i);

        $display("All tests passed");
        $finish;
    end

endmodule

// File: compile.f
hdl/ooo_pkg.sv
hdl/alu.sv
hdl/arith.sv
hdl/arith_rs.sv
hdl/arith_unit_top.sv
sim/tb_clock_gen.sv
sim/tb_arith_unit.sv

// File: Makefile
VERILATOR ?= verilator
TOP       ?= tb_arith_unit
FLAGS     ?= --binary --timing --assert --timescale 1ns/1ps

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(FLAGS) --top-module $(TOP) -f compile.f

run: build
	./obj_dir/V$(TOP)

lint:
	$(VERILATOR) --lint-only --timing --assert --timescale 1ns/1ps --top-module $(TOP) -f compile.f

clean:
	rm -rf obj_dir
